// ==== common/rot_settings.svh ====
`ifndef ROT_SETTINGS_SVH
`define ROT_SETTINGS_SVH

// bus widths
`define ROT_DATA_W 32
`define ROT_ADDR_W 4

// word addresses on the wishbone port
`define ROT_ADDR_OP     4'h0
`define ROT_ADDR_STATUS 4'h1
`define ROT_ADDR_UNLOCK 4'h2
`define ROT_ADDR_RNG0   4'h4 // pool words at RNG0..RNG0+3

// obfuscation sequence, checked msb first
`define ROT_UNLOCK_SEQ 32'hF0F0_AAAA

// random pool
`define ROT_RNG_W     128
`define ROT_LFSR_W    32
`define ROT_RNG_SEED  32'h0000_0001
`define ROT_RNG_LIMIT 6
`define ROT_RNG_CNT_W 3 // holds 0..ROT_RNG_LIMIT

`endif

// ==== common/rot_pkg.sv ====
`include "rot_settings.svh"

package rot_pkg;

	typedef enum logic [`ROT_DATA_W-1:0] {
		OP_NOP          = 0,
		OP_STATUS_CLEAR = 1,
		OP_RNG_GEN      = 2,
		OP_RNG_CLEAR    = 3
	} rot_op_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_UNLOCK,
		ST_RNG_GEN
	} rot_state_e;

	typedef struct packed {
		logic op_valid;
		rot_op_e op;
		logic unlock_valid;
		logic [`ROT_DATA_W-1:0] candidate;
	} rot_cmd_t;

	// field order gives the register layout, busy at bit 31
	typedef struct packed {
		logic busy;
		logic unlocked;
		logic rng_valid;
		logic [`ROT_RNG_CNT_W-1:0] rng_count;
		logic [`ROT_DATA_W-4-`ROT_RNG_CNT_W:0] rsvd;
	} rot_status_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`ROT_ADDR_W-1:0] adr;
		logic [`ROT_DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [`ROT_DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage

// ==== design/rot_regs.sv ====
`timescale 1ns/10ps
`include "rot_settings.svh"

module rot_regs (
	input logic clk,
	input logic rst_n,
	input rot_pkg::wb_req_t wb_i,
	output rot_pkg::wb_rsp_t wb_o,
	output rot_pkg::rot_cmd_t cmd_o,
	input rot_pkg::rot_status_t status_i,
	input rot_pkg::rot_op_e last_op_i,
	input logic [`ROT_RNG_W-1:0] pool_i
);
	import rot_pkg::*;

	localparam logic [`ROT_ADDR_W-1:0] ADR_RNG1 = `ROT_ADDR_RNG0 + 1;
	localparam logic [`ROT_ADDR_W-1:0] ADR_RNG2 = `ROT_ADDR_RNG0 + 2;
	localparam logic [`ROT_ADDR_W-1:0] ADR_RNG3 = `ROT_ADDR_RNG0 + 3;

	logic ack_q;
	logic req;
	logic wr_op;
	logic wr_unlock;
	logic op_valid_q;
	logic unlock_valid_q;
	logic [`ROT_DATA_W-1:0] wdata_q;
	logic [`ROT_DATA_W-1:0] rdata;

	// new access seen, ack follows next cycle
	assign req = wb_i.cyc && wb_i.stb && !ack_q;
	assign wr_op = req && wb_i.we && (wb_i.adr == `ROT_ADDR_OP);
	assign wr_unlock = req && wb_i.we && (wb_i.adr == `ROT_ADDR_UNLOCK);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			op_valid_q <= 1'b0;
			unlock_valid_q <= 1'b0;
		end else begin
			ack_q <= req; // single cycle, req drops while ack is high
			op_valid_q <= wr_op;
			unlock_valid_q <= wr_unlock;
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			wdata_q <= wb_i.dat;
		end
	end

	// command pulses line up with the ack cycle
	always_comb begin
		cmd_o.op_valid = op_valid_q;
		cmd_o.op = rot_op_e'(wdata_q);
		cmd_o.unlock_valid = unlock_valid_q;
		cmd_o.candidate = wdata_q;
	end

	always_comb begin
		case (wb_i.adr)
			`ROT_ADDR_OP: begin
				rdata = last_op_i;
			end
			`ROT_ADDR_STATUS: begin
				rdata = status_i;
			end
			`ROT_ADDR_RNG0: begin
				rdata = pool_i[31:0];
			end
			ADR_RNG1: begin
				rdata = pool_i[63:32];
			end
			ADR_RNG2: begin
				rdata = pool_i[95:64];
			end
			ADR_RNG3: begin
				rdata = pool_i[127:96];
			end
			default: begin
				rdata = '0; // unlock is write only
			end
		endcase
	end

	always_comb begin
		wb_o.ack = ack_q;
		if (ack_q && !wb_i.we) begin
			wb_o.dat = rdata;
		end else begin
			wb_o.dat = '0;
		end
	end

endmodule

// ==== design/rot_sequencer.sv ====
`timescale 1ns/10ps
`include "rot_settings.svh"

module rot_sequencer (
	input logic clk,
	input logic rst_n,
	input rot_pkg::rot_cmd_t cmd_i,
	output rot_pkg::rot_status_t status_o,
	output rot_pkg::rot_op_e last_op_o,
	output logic unlock_start_o,
	output logic [`ROT_DATA_W-1:0] candidate_o,
	input logic unlock_done_i,
	input logic unlock_match_i,
	output logic rng_gen_o,
	output logic rng_clear_o,
	input logic rng_done_i
);
	import rot_pkg::*;

	rot_state_e state_q;
	logic unlocked_q;
	logic rng_valid_q;
	logic [`ROT_RNG_CNT_W-1:0] rng_count_q;
	logic op_ok;
	logic accept_op;
	logic accept_unlock;

	always_comb begin
		case (cmd_i.op)
			OP_NOP, OP_STATUS_CLEAR, OP_RNG_CLEAR: begin
				op_ok = 1'b1;
			end
			OP_RNG_GEN: begin
				op_ok = (rng_count_q < `ROT_RNG_LIMIT);
			end
			default: begin
				op_ok = 1'b0; // unknown opcode dropped
			end
		endcase
	end

	assign accept_unlock = (state_q == ST_IDLE) && cmd_i.unlock_valid;
	assign accept_op = (state_q == ST_IDLE) && cmd_i.op_valid && unlocked_q && op_ok;
	assign rng_clear_o = accept_op && (cmd_i.op == OP_RNG_CLEAR);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			unlocked_q <= 1'b0;
			rng_valid_q <= 1'b0;
			rng_count_q <= '0;
			last_op_o <= OP_NOP;
			unlock_start_o <= 1'b0;
			rng_gen_o <= 1'b0;
		end else begin
			unlock_start_o <= 1'b0;
			rng_gen_o <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (accept_unlock) begin
						state_q <= ST_UNLOCK;
						unlock_start_o <= 1'b1;
					end else if (accept_op) begin
						last_op_o <= cmd_i.op;
						case (cmd_i.op)
							OP_STATUS_CLEAR: begin
								rng_valid_q <= 1'b0;
								rng_count_q <= '0;
							end
							OP_RNG_CLEAR: begin
								rng_valid_q <= 1'b0; // count kept
							end
							OP_RNG_GEN: begin
								state_q <= ST_RNG_GEN;
								rng_gen_o <= 1'b1;
							end
							default: begin
							end
						endcase
					end
				end
				ST_UNLOCK: begin
					if (unlock_done_i) begin
						unlocked_q <= unlock_match_i; // a miss relocks
						state_q <= ST_IDLE;
					end
				end
				ST_RNG_GEN: begin
					if (rng_done_i) begin
						rng_count_q <= rng_count_q + 1'b1;
						rng_valid_q <= 1'b1;
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept_unlock) begin
			candidate_o <= cmd_i.candidate;
		end
	end

	always_comb begin
		status_o = '0;
		status_o.busy = (state_q != ST_IDLE);
		status_o.unlocked = unlocked_q;
		status_o.rng_valid = rng_valid_q;
		status_o.rng_count = rng_count_q;
	end

endmodule

// ==== design/rot_unlock.sv ====
`timescale 1ns/10ps
`include "rot_settings.svh"

module rot_unlock (
	input logic clk,
	input logic rst_n,
	input logic start_i,
	input logic [`ROT_DATA_W-1:0] candidate_i,
	output logic done_o,
	output logic match_o
);

	localparam int IDX_W = $clog2(`ROT_DATA_W);
	localparam logic [`ROT_DATA_W-1:0] UNLOCK_SEQ = `ROT_UNLOCK_SEQ;

	logic active_q;
	logic [IDX_W-1:0] idx_q;
	logic run_match_q;
	logic bit_ok;

	// candidate_i is held by the sequencer for the whole check
	assign bit_ok = (candidate_i[idx_q] == UNLOCK_SEQ[idx_q]);
	assign done_o = active_q && (idx_q == '0);
	assign match_o = run_match_q && bit_ok; // valid with done_o

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			idx_q <= '0;
			run_match_q <= 1'b0;
		end else if (start_i) begin
			active_q <= 1'b1;
			idx_q <= IDX_W'(`ROT_DATA_W - 1); // msb first
			run_match_q <= 1'b1;
		end else if (active_q) begin
			run_match_q <= run_match_q && bit_ok;
			idx_q <= idx_q - 1'b1;
			if (idx_q == '0) begin
				active_q <= 1'b0;
			end
		end
	end

endmodule

// ==== rng/rot_rng.sv ====
`timescale 1ns/10ps
`include "rot_settings.svh"

module rot_rng (
	input logic clk,
	input logic rst_n,
	input logic gen_i,
	input logic clear_i,
	output logic done_o,
	output logic [`ROT_RNG_W-1:0] pool_o
);

	localparam int STEP_W = $clog2(`ROT_RNG_W);

	logic [`ROT_LFSR_W-1:0] lfsr_q;
	logic [STEP_W-1:0] step_q;
	logic active_q;
	logic fb;

	// taps 32, 22, 2, 1
	assign fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
	assign done_o = active_q && (step_q == STEP_W'(`ROT_RNG_W - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr_q <= `ROT_RNG_SEED;
			step_q <= '0;
			active_q <= 1'b0;
		end else if (gen_i) begin
			active_q <= 1'b1;
			step_q <= '0;
		end else if (active_q) begin
			lfsr_q <= {lfsr_q[`ROT_LFSR_W-2:0], fb};
			step_q <= step_q + 1'b1;
			if (done_o) begin
				active_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pool_o <= '0;
		end else if (clear_i) begin
			pool_o <= '0; // lfsr keeps running state
		end else if (active_q) begin
			pool_o <= {pool_o[`ROT_RNG_W-2:0], fb}; // new bit at 0
		end
	end

endmodule

// ==== design/rot_top.sv ====
`timescale 1ns/10ps
`include "rot_settings.svh"

module rot_top (
	input logic clk,
	input logic rst_n,
	input rot_pkg::wb_req_t wb_i,
	output rot_pkg::wb_rsp_t wb_o
);
	import rot_pkg::*;

	rot_cmd_t cmd;
	rot_status_t status;
	rot_op_e last_op;
	logic unlock_start;
	logic [`ROT_DATA_W-1:0] candidate;
	logic unlock_done;
	logic unlock_match;
	logic rng_gen;
	logic rng_clear;
	logic rng_done;
	logic [`ROT_RNG_W-1:0] pool;

	rot_regs regs0 (
		.clk(clk),
		.rst_n(rst_n),
		.wb_i(wb_i),
		.wb_o(wb_o),
		.cmd_o(cmd),
		.status_i(status),
		.last_op_i(last_op),
		.pool_i(pool)
	);

	rot_sequencer seq0 (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_i(cmd),
		.status_o(status),
		.last_op_o(last_op),
		.unlock_start_o(unlock_start),
		.candidate_o(candidate),
		.unlock_done_i(unlock_done),
		.unlock_match_i(unlock_match),
		.rng_gen_o(rng_gen),
		.rng_clear_o(rng_clear),
		.rng_done_i(rng_done)
	);

	rot_unlock unlock0 (
		.clk(clk),
		.rst_n(rst_n),
		.start_i(unlock_start),
		.candidate_i(candidate),
		.done_o(unlock_done),
		.match_o(unlock_match)
	);

	rot_rng rng0 (
		.clk(clk),
		.rst_n(rst_n),
		.gen_i(rng_gen),
		.clear_i(rng_clear),
		.done_o(rng_done),
		.pool_o(pool)
	);

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#2 clk_o = ~clk_o; // 4 ns period
		end
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (4) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

// ==== tb/rot_tb.sv ====
`timescale 1ns/10ps
`include "rot_settings.svh"

module rot_tb;
	import rot_pkg::*;

	localparam int ADDR_W = `ROT_ADDR_W;
	localparam int ACK_LIMIT = 16;
	localparam int POLL_LIMIT = 200; // a generation needs about 45 status reads
	localparam int RESET_LIMIT = 32;
	localparam logic [31:0] UNLOCK_SEQ = `ROT_UNLOCK_SEQ;

	logic clk;
	logic rst_n;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [31:0] rnd_state;
	int tests;
	int checks;
	int errors;
	int errors_before;

	// reference model of the controller
	logic m_unlocked;
	logic m_valid;
	logic [`ROT_RNG_CNT_W-1:0] m_count;
	rot_op_e m_last_op;
	logic [31:0] m_lfsr;
	logic [`ROT_RNG_W-1:0] m_pool;

	tb_clkgen clkgen0 (
		.clk_o(clk),
		.rst_n_o(rst_n)
	);

	rot_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.wb_i(wb_req),
		.wb_o(wb_rsp)
	);

	// fibonacci lfsr, taps 32 22 2 1, new bit enters at bit 0
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			rnd_state = lfsr_step(rnd_state);
			v = {v[30:0], rnd_state[0]};
		end
	endtask

	task automatic abort_run(input string why);
		errors++;
		$display("%0t ns: %s", $time, why);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic check_status(input string name, input rot_status_t got,
			input rot_status_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_op(input string name, input rot_op_e got, input rot_op_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (rst_n !== 1'b1 && n < RESET_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) abort_run("reset was never released");
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!wb_rsp.ack && n < ACK_LIMIT);
		if (!wb_rsp.ack) abort_run("wishbone access was never acknowledged");
	endtask

	task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [31:0] dat);
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		wait_ack();
		wb_req <= '0;
	endtask

	task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [31:0] dat);
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
		wait_ack();
		dat = wb_rsp.dat; // sampled on the ack cycle
		wb_req <= '0;
	endtask

	task automatic poll_idle();
		logic [31:0] v;
		rot_status_t st;
		int n;
		n = 0;
		do begin
			wb_read(`ROT_ADDR_STATUS, v);
			st = rot_status_t'(v);
			n++;
		end while (st.busy && n < POLL_LIMIT);
		if (st.busy) abort_run("controller stayed busy past the polling limit");
	endtask

	function automatic rot_status_t model_status();
		rot_status_t s;
		s = '0;
		s.unlocked = m_unlocked;
		s.rng_valid = m_valid;
		s.rng_count = m_count;
		return s;
	endfunction

	task automatic model_op(input rot_op_e op);
		if (m_unlocked && (op != OP_RNG_GEN || m_count < `ROT_RNG_LIMIT)) begin
			m_last_op = op;
			if (op == OP_STATUS_CLEAR) begin
				m_valid = 1'b0;
				m_count = '0;
			end else if (op == OP_RNG_CLEAR) begin
				m_valid = 1'b0;
				m_pool = '0;
			end else if (op == OP_RNG_GEN) begin
				for (int i = 0; i < `ROT_RNG_W; i++) begin
					m_lfsr = lfsr_step(m_lfsr);
					m_pool = {m_pool[`ROT_RNG_W-2:0], m_lfsr[0]};
				end
				m_valid = 1'b1;
				m_count = m_count + 1'b1;
			end
		end
	endtask

	task automatic write_op(input rot_op_e op);
		wb_write(`ROT_ADDR_OP, op);
		poll_idle();
		model_op(op);
	endtask

	task automatic write_unlock(input logic [31:0] cand);
		wb_write(`ROT_ADDR_UNLOCK, cand);
		poll_idle();
		m_unlocked = (cand == UNLOCK_SEQ);
	endtask

	task automatic check_regs();
		logic [31:0] v;
		wb_read(`ROT_ADDR_STATUS, v);
		check_status("STATUS", rot_status_t'(v), model_status());
		wb_read(`ROT_ADDR_OP, v);
		check_op("OP", rot_op_e'(v), m_last_op);
		for (int w = 0; w < 4; w++) begin
			wb_read(ADDR_W'(`ROT_ADDR_RNG0 + w), v);
			check_word($sformatf("RNG%0d", w), v, m_pool[w*32 +: 32]);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			$display("test %0d %s: %0d errors", tests, name, errors - errors_before);
		end
		errors_before = errors;
	endtask

	initial begin
		logic [31:0] v;
		logic [31:0] r;
		logic [31:0] cand;
		wb_req = '0;
		rnd_state = 32'h6a34_85d9;
		tests = 0;
		checks = 0;
		errors = 0;
		errors_before = 0;
		m_unlocked = 1'b0;
		m_valid = 1'b0;
		m_count = '0;
		m_last_op = OP_NOP;
		m_lfsr = `ROT_RNG_SEED;
		m_pool = '0;
		wait_reset();

		check_regs();
		wb_read(ADDR_W'(3), v);
		check_word("ADR3", v, '0);
		rand_bits(3, r);
		wb_read(ADDR_W'(8 + r[2:0]), v); // upper half is unmapped
		check_word($sformatf("ADR%0d", 8 + r[2:0]), v, '0);
		end_test("reset values");

		write_op(OP_RNG_GEN);
		write_op(OP_STATUS_CLEAR);
		check_regs();
		end_test("locked commands");

		for (int i = 0; i < 4; i++) begin
			rand_bits(32, cand);
			rand_bits(5, r);
			cand[r[4:0]] = ~UNLOCK_SEQ[r[4:0]]; // at least one bit off
			write_unlock(cand);
			check_regs();
		end
		write_unlock(UNLOCK_SEQ);
		check_regs();
		end_test("unlock");

		for (int g = 0; g < `ROT_RNG_LIMIT; g++) begin
			write_op(OP_RNG_GEN);
			check_regs();
		end
		// op must stay at nop when the run past the limit is refused
		write_op(OP_NOP);
		write_op(OP_RNG_GEN);
		check_regs();
		end_test("rng generate");

		write_op(OP_RNG_CLEAR);
		check_regs();
		write_op(OP_STATUS_CLEAR);
		check_regs();
		write_op(OP_NOP);
		check_regs();
		end_test("clears");

		rand_bits(32, cand);
		rand_bits(5, r);
		cand[r[4:0]] = ~UNLOCK_SEQ[r[4:0]];
		write_unlock(cand);
		check_regs();
		write_op(OP_RNG_GEN);
		check_regs();
		end_test("relock");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+common
common/rot_pkg.sv
design/rot_regs.sv
design/rot_sequencer.sv
design/rot_unlock.sv
rng/rot_rng.sv
design/rot_top.sv
tb/tb_clkgen.sv
tb/rot_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f sim.f --top-module rot_tb -o rot_sim
./obj_dir/rot_sim > sim.log
cat sim.log

if grep -qx "Simulation completed successfully" sim.log; then
	exit 0
fi
exit 1
